// File: Bender.yml
package:
  name: aes

export_include_dirs:
  - include

sources:
  - files:
      - rtl/aes_pkg.sv
      - rtl/aes_reg_if.sv
      - rtl/aes_prng.sv
      - rtl/aes_sync_reqack_data.sv
      - rtl/aes_core.sv
      - rtl/aes.sv
  - target: simulation
    files:
      - verification/aes_tb_clk.sv
      - verification/aes_tb.sv

// File: aes.f
+incdir+include
rtl/aes_pkg.sv
rtl/aes_reg_if.sv
rtl/aes_prng.sv
rtl/aes_sync_reqack_data.sv
rtl/aes_core.sv
rtl/aes.sv
verification/aes_tb_clk.sv
verification/aes_tb.sv

// File: include/aes_cfg.svh
//////////////////////////////////////////////////////////////////////
// AES entropy subsystem configuration
// Widths, register map, LFSR polynomial, reset seeds and the
// masking PRNG reseed period
//////////////////////////////////////////////////////////////////////

`ifndef AES_CFG_SVH
`define AES_CFG_SVH

`define AES_ENTROPY_W          32
`define AES_ADDR_W             5
`define AES_DATA_W             32

// Register map
`define AES_ADDR_CTRL          5'h00
`define AES_ADDR_STATUS        5'h04
`define AES_ADDR_CLEAR_DATA    5'h08
`define AES_ADDR_MASK_DATA     5'h0C
`define AES_ADDR_ALERT_TEST    5'h10

// Galois feedback mask and seeds, a seed also replaces zero entropy
`define AES_LFSR_POLY          32'h80200003
`define AES_LFSR_SEED_CLEAR    32'h5A3C96E1
`define AES_LFSR_SEED_MASK     32'hC3A50F17

// Masking words between automatic reseeds
`define AES_MASK_RESEED_PERIOD 8

`endif

// File: rtl/aes.sv
//////////////////////////////////////////////////////////////////////
// AES entropy and alert subsystem, top level
// Register port, escalation synchronizer, EDN arbitration with
// request hold, clock domain crossing to the EDN, entropy core
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "aes_cfg.svh"

module aes
  import aes_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clk_edn_i,
  input  logic      rst_edn_ni,

  // Register port
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,

  // Life cycle escalation level
  input  logic      lc_escalate_en_i,

  // EDN
  output logic      edn_req_o,
  input  logic      edn_ack_i,
  input  entropy_t  edn_data_i,

  // Status and alerts
  output logic      idle_o,
  output logic      alert_recov_o,
  output logic      alert_fatal_o
);

  logic     clear_reseed, mask_reseed;
  logic     clear_next, mask_next;
  logic     test_recov, test_fatal;
  logic     clear_busy, mask_busy;
  logic     fatal;
  entropy_t clear_word, mask_word;

  logic     esc_s1_q, esc_s2_q;

  logic     entropy_clearing_req, entropy_masking_req;
  logic     entropy_clearing_ack, entropy_masking_ack;
  logic     edn_req_int;
  logic     edn_req;
  logic     edn_req_hold_d, edn_req_hold_q;
  logic     edn_ack;
  entropy_t edn_data;

  aes_reg_if u_reg_if (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .reg_we_i       (reg_we_i),
    .reg_re_i       (reg_re_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .idle_i         (idle_o),
    .clear_busy_i   (clear_busy),
    .mask_busy_i    (mask_busy),
    .fatal_i        (fatal),
    .clear_word_i   (clear_word),
    .mask_word_i    (mask_word),
    .clear_reseed_o (clear_reseed),
    .mask_reseed_o  (mask_reseed),
    .clear_next_o   (clear_next),
    .mask_next_o    (mask_next),
    .test_recov_o   (test_recov),
    .test_fatal_o   (test_fatal)
  );

  // Escalation level into the clk_i domain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      esc_s1_q <= 1'b0;
      esc_s2_q <= 1'b0;
    end else begin
      esc_s1_q <= lc_escalate_en_i;
      esc_s2_q <= esc_s1_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EDN arbitration
  //////////////////////////////////////////////////////////////////////

  // Clearing PRNG wins when both ask
  assign edn_req_int          = entropy_clearing_req | entropy_masking_req;
  assign entropy_clearing_ack = entropy_clearing_req & edn_ack;
  assign entropy_masking_ack  = ~entropy_clearing_req & entropy_masking_req & edn_ack;

  // A request dropped on escalation stays open until the EDN answers
  assign edn_req        = edn_req_int | edn_req_hold_q;
  assign edn_req_hold_d = edn_req & ~edn_ack;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edn_req_hold_q <= 1'b0;
    end else begin
      edn_req_hold_q <= edn_req_hold_d;
    end
  end

  aes_sync_reqack_data #(
    .Width (`AES_ENTROPY_W)
  ) u_sync_edn (
    .clk_src_i  (clk_i),
    .rst_src_ni (rst_ni),
    .clk_dst_i  (clk_edn_i),
    .rst_dst_ni (rst_edn_ni),
    .src_req_i  (edn_req),
    .src_ack_o  (edn_ack),
    .dst_req_o  (edn_req_o),
    .dst_ack_i  (edn_ack_i),
    .data_i     (edn_data_i),
    .data_o     (edn_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////////////////////////

  aes_core u_core (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .escalate_i             (esc_s2_q),
    .clear_reseed_i         (clear_reseed),
    .mask_reseed_i          (mask_reseed),
    .clear_next_i           (clear_next),
    .mask_next_i            (mask_next),
    .test_recov_i           (test_recov),
    .test_fatal_i           (test_fatal),
    .entropy_clearing_req_o (entropy_clearing_req),
    .entropy_clearing_ack_i (entropy_clearing_ack),
    .entropy_masking_req_o  (entropy_masking_req),
    .entropy_masking_ack_i  (entropy_masking_ack),
    .entropy_i              (edn_data),
    .clear_busy_o           (clear_busy),
    .mask_busy_o            (mask_busy),
    .clear_word_o           (clear_word),
    .mask_word_o            (mask_word),
    .fatal_o                (fatal),
    .alert_recov_o          (alert_recov_o),
    .alert_fatal_o          (alert_fatal_o)
  );

  // Busy while any reseed or held EDN request is open
  assign idle_o = ~(clear_busy | mask_busy | edn_req_hold_q);

endmodule

`default_nettype wire

// File: rtl/aes_core.sv
//////////////////////////////////////////////////////////////////////
// Entropy core
// Clearing and masking PRNGs, escalation freeze, alert generation
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "aes_cfg.svh"

module aes_core
  import aes_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     escalate_i,
  input  logic     clear_reseed_i,
  input  logic     mask_reseed_i,
  input  logic     clear_next_i,
  input  logic     mask_next_i,
  input  logic     test_recov_i,
  input  logic     test_fatal_i,
  output logic     entropy_clearing_req_o,
  input  logic     entropy_clearing_ack_i,
  output logic     entropy_masking_req_o,
  input  logic     entropy_masking_ack_i,
  input  entropy_t entropy_i,
  output logic     clear_busy_o,
  output logic     mask_busy_o,
  output entropy_t clear_word_o,
  output entropy_t mask_word_o,
  output logic     fatal_o,
  output logic     alert_recov_o,
  output logic     alert_fatal_o
);

  logic fatal_q;
  logic freeze;
  logic recov_q;
  logic test_fatal_q;

  // Escalation freezes at once, the latch keeps it until reset
  assign freeze  = escalate_i | fatal_q;
  assign fatal_o = freeze;

  aes_prng #(
    .Seed (`AES_LFSR_SEED_CLEAR)
  ) u_prng_clearing (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_i      (clear_reseed_i),
    .next_i        (clear_next_i),
    .auto_en_i     (1'b0),
    .freeze_i      (freeze),
    .entropy_req_o (entropy_clearing_req_o),
    .entropy_ack_i (entropy_clearing_ack_i),
    .entropy_i     (entropy_i),
    .busy_o        (clear_busy_o),
    .word_o        (clear_word_o)
  );

  // Masking PRNG also reseeds itself
  aes_prng #(
    .Seed (`AES_LFSR_SEED_MASK)
  ) u_prng_masking (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_i      (mask_reseed_i),
    .next_i        (mask_next_i),
    .auto_en_i     (1'b1),
    .freeze_i      (freeze),
    .entropy_req_o (entropy_masking_req_o),
    .entropy_ack_i (entropy_masking_ack_i),
    .entropy_i     (entropy_i),
    .busy_o        (mask_busy_o),
    .word_o        (mask_word_o)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fatal_q      <= 1'b0;
      recov_q      <= 1'b0;
      test_fatal_q <= 1'b0;
    end else begin
      fatal_q      <= fatal_q | escalate_i;
      // Reseed command while that PRNG is still busy
      recov_q      <= test_recov_i
                    | (clear_reseed_i & clear_busy_o)
                    | (mask_reseed_i & mask_busy_o);
      test_fatal_q <= test_fatal_i;
    end
  end

  assign alert_recov_o = recov_q;
  assign alert_fatal_o = freeze | test_fatal_q;

endmodule

`default_nettype wire

// File: rtl/aes_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the AES entropy subsystem
// Entropy word, register address and data, reseed FSM states
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

  // One EDN entropy word, also the PRNG state width
  typedef logic [`AES_ENTROPY_W-1:0] entropy_t;

  // Register port
  typedef logic [`AES_ADDR_W-1:0] reg_addr_t;
  typedef logic [`AES_DATA_W-1:0] reg_data_t;

  // PRNG reseed FSM
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DONE
  } reseed_state_e;

endpackage

`default_nettype wire

// File: rtl/aes_prng.sv
//////////////////////////////////////////////////////////////////////
// 32-bit Galois LFSR PRNG
// Reseed FSM with EDN request/acknowledge and optional automatic
// reseed after a fixed number of output words
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "aes_cfg.svh"

module aes_prng
  import aes_pkg::*;
#(
  parameter entropy_t Seed = `AES_LFSR_SEED_CLEAR
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     reseed_i,
  input  logic     next_i,
  input  logic     auto_en_i,
  input  logic     freeze_i,
  output logic     entropy_req_o,
  input  logic     entropy_ack_i,
  input  entropy_t entropy_i,
  output logic     busy_o,
  output entropy_t word_o
);

  localparam int unsigned CntW = $clog2(`AES_MASK_RESEED_PERIOD + 1);
  localparam logic [CntW-1:0] CntLast = CntW'(`AES_MASK_RESEED_PERIOD - 1);

  reseed_state_e   state_d, state_q;
  entropy_t        lfsr_d, lfsr_q;
  entropy_t        lfsr_step;
  entropy_t        seed_word;
  logic [CntW-1:0] cnt_d, cnt_q;
  logic            step;
  logic            auto_trig;
  logic            start;

  // Shift right, fold the polynomial back in when a one falls out
  assign lfsr_step = {1'b0, lfsr_q[`AES_ENTROPY_W-1:1]}
                   ^ (lfsr_q[0] ? entropy_t'(`AES_LFSR_POLY) : '0);

  // All-zero entropy would lock the LFSR
  assign seed_word = (entropy_i == '0) ? Seed : entropy_i;

  assign step      = next_i & ~freeze_i;
  assign auto_trig = auto_en_i & step & (cnt_q == CntLast) & (state_q == IDLE);
  assign start     = (reseed_i | auto_trig) & ~freeze_i;

  always_comb begin
    state_d = state_q;
    lfsr_d  = step ? lfsr_step : lfsr_q;
    case (state_q)
      IDLE: begin
        if (start) state_d = REQ;
      end
      REQ: begin
        if (entropy_ack_i) begin
          lfsr_d  = seed_word;
          state_d = WAIT_DONE;
        end
      end
      // New state is loaded, busy drops on leaving
      WAIT_DONE: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
    if (freeze_i) state_d = IDLE;
  end

  // Words advanced since the last automatic reseed
  always_comb begin
    cnt_d = cnt_q;
    if (!auto_en_i || auto_trig) begin
      cnt_d = '0;
    end else if (step && cnt_q != CntLast) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      lfsr_q  <= Seed;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      lfsr_q  <= lfsr_d;
      cnt_q   <= cnt_d;
    end
  end

  assign entropy_req_o = (state_q == REQ) & ~freeze_i;
  assign busy_o        = (state_q != IDLE);
  assign word_o        = freeze_i ? '0 : lfsr_q;

endmodule

`default_nettype wire

// File: rtl/aes_reg_if.sv
//////////////////////////////////////////////////////////////////////
// Strobe-based register port
// Address decode, write and read-advance pulses, registered read data
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "aes_cfg.svh"

module aes_reg_if
  import aes_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  input  logic      idle_i,
  input  logic      clear_busy_i,
  input  logic      mask_busy_i,
  input  logic      fatal_i,
  input  entropy_t  clear_word_i,
  input  entropy_t  mask_word_i,
  output logic      clear_reseed_o,
  output logic      mask_reseed_o,
  output logic      clear_next_o,
  output logic      mask_next_o,
  output logic      test_recov_o,
  output logic      test_fatal_o
);

  logic      sel_ctrl;
  logic      sel_clear;
  logic      sel_mask;
  logic      sel_test;
  reg_data_t rdata_d;
  reg_data_t rdata_q;

  assign sel_ctrl  = (reg_addr_i == `AES_ADDR_CTRL);
  assign sel_clear = (reg_addr_i == `AES_ADDR_CLEAR_DATA);
  assign sel_mask  = (reg_addr_i == `AES_ADDR_MASK_DATA);
  assign sel_test  = (reg_addr_i == `AES_ADDR_ALERT_TEST);

  // Write pulses act at the edge that samples the strobe
  assign clear_reseed_o = reg_we_i & sel_ctrl & reg_wdata_i[0];
  assign mask_reseed_o  = reg_we_i & sel_ctrl & reg_wdata_i[1];
  assign test_recov_o   = reg_we_i & sel_test & reg_wdata_i[0];
  assign test_fatal_o   = reg_we_i & sel_test & reg_wdata_i[1];

  // A data read steps the PRNG at the same edge that captures its word
  assign clear_next_o = reg_re_i & sel_clear;
  assign mask_next_o  = reg_re_i & sel_mask;

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      `AES_ADDR_STATUS: begin
        rdata_d[0] = idle_i;
        rdata_d[1] = clear_busy_i;
        rdata_d[2] = mask_busy_i;
        rdata_d[3] = fatal_i;
      end
      `AES_ADDR_CLEAR_DATA: rdata_d = reg_data_t'(clear_word_i);
      `AES_ADDR_MASK_DATA:  rdata_d = reg_data_t'(mask_word_i);
      default:              rdata_d = '0;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/aes_sync_reqack_data.sv
//////////////////////////////////////////////////////////////////////
// Request/acknowledge synchronizer with data from the destination
// Toggle based handshake, two-flop synchronizers in each direction
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module aes_sync_reqack_data #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_src_i,
  input  logic             rst_src_ni,
  input  logic             clk_dst_i,
  input  logic             rst_dst_ni,
  input  logic             src_req_i,
  output logic             src_ack_o,
  output logic             dst_req_o,
  input  logic             dst_ack_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Source domain
  logic             src_busy_q;
  logic             src_tgl_q;
  logic             ack_tgl_s1_q;
  logic             ack_tgl_s2_q;
  logic             ack_seen;

  // Destination domain
  logic             req_tgl_s1_q;
  logic             req_tgl_s2_q;
  logic             dst_tgl_q;
  logic             dst_done;
  logic [Width-1:0] data_q;

  //////////////////////////////////////////////////////////////////////
  // Source side
  //////////////////////////////////////////////////////////////////////

  // Returned toggle matches ours once the destination has answered
  assign ack_seen  = src_busy_q & (ack_tgl_s2_q == src_tgl_q);
  assign src_ack_o = ack_seen;

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      src_busy_q   <= 1'b0;
      src_tgl_q    <= 1'b0;
      ack_tgl_s1_q <= 1'b0;
      ack_tgl_s2_q <= 1'b0;
    end else begin
      ack_tgl_s1_q <= dst_tgl_q;
      ack_tgl_s2_q <= ack_tgl_s1_q;
      if (!src_busy_q && src_req_i) begin
        src_busy_q <= 1'b1;
        src_tgl_q  <= ~src_tgl_q;
      end else if (ack_seen) begin
        src_busy_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Destination side
  //////////////////////////////////////////////////////////////////////

  // Request is open while the toggles differ
  assign dst_req_o = req_tgl_s2_q ^ dst_tgl_q;
  assign dst_done  = dst_req_o & dst_ack_i;

  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      req_tgl_s1_q <= 1'b0;
      req_tgl_s2_q <= 1'b0;
      dst_tgl_q    <= 1'b0;
    end else begin
      req_tgl_s1_q <= src_tgl_q;
      req_tgl_s2_q <= req_tgl_s1_q;
      if (dst_done) dst_tgl_q <= ~dst_tgl_q;
    end
  end

  // Captured word stays put until the next handshake completes
  always_ff @(posedge clk_dst_i) begin
    if (dst_done) data_q <= data_i;
  end

  assign data_o = data_q;

endmodule

`default_nettype wire

// File: verification/aes_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the AES entropy and alert subsystem
// EDN responder model, register tasks, reference LFSR model,
// compare tasks and the directed test sequence
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

`include "aes_cfg.svh"

module aes_tb
  import aes_pkg::*;
();

  logic      clk, clk_edn;
  logic      rst_n, rst_edn_n;
  logic      reg_we, reg_re;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata, reg_rdata;
  logic      lc_escalate_en;
  logic      edn_req;
  logic      edn_ack = 1'b0;
  entropy_t  edn_data = '0;
  logic      idle, alert_recov, alert_fatal;

  // Responder state and controls from the test sequence
  integer    seed = 32'he22d;
  entropy_t  edn_words[$];
  entropy_t  edn_word;
  bit        edn_wait = 1'b0;
  int        edn_delay = 0;
  bit        hold_ack;
  bit        force_zero;

  // Reference model state
  entropy_t  clear_state, mask_state;
  int        mask_reads;
  int        errors, checks;

  aes_tb_clk #(.Period(4.0)) u_clk (.clk_o(clk));
  aes_tb_clk #(.Period(6.0)) u_clk_edn (.clk_o(clk_edn));

  aes uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .clk_edn_i        (clk_edn),
    .rst_edn_ni       (rst_edn_n),
    .reg_we_i         (reg_we),
    .reg_re_i         (reg_re),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rdata_o      (reg_rdata),
    .lc_escalate_en_i (lc_escalate_en),
    .edn_req_o        (edn_req),
    .edn_ack_i        (edn_ack),
    .edn_data_i       (edn_data),
    .idle_o           (idle),
    .alert_recov_o    (alert_recov),
    .alert_fatal_o    (alert_fatal)
  );

  //////////////////////////////////////////////////////////////////////
  // EDN responder
  //////////////////////////////////////////////////////////////////////

  // Answers each request after 0 to 5 EDN cycles unless held back
  always @(negedge clk_edn) begin
    edn_ack = 1'b0;
    if (!rst_edn_n) begin
      edn_wait = 1'b0;
    end else begin
      if (!edn_wait && edn_req) begin
        edn_wait  = 1'b1;
        edn_delay = {$random(seed)} % 6;
      end
      if (edn_wait && !hold_ack) begin
        if (edn_delay == 0) begin
          edn_word = force_zero ? '0 : entropy_t'($random(seed));
          edn_data = edn_word;
          edn_ack  = 1'b1;
          edn_words.push_back(edn_word);
          edn_wait = 1'b0;
        end else begin
          edn_delay--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic entropy_t lfsr_step(input entropy_t state);
    entropy_t shifted;
    shifted = state >> 1;
    if (state[0]) shifted = shifted ^ entropy_t'(`AES_LFSR_POLY);
    return shifted;
  endfunction

  // Zero entropy falls back to the seed
  function automatic entropy_t reseed_value(input entropy_t word, input entropy_t seed_word);
    return (word == '0) ? seed_word : word;
  endfunction

  task automatic check_word(input string name, input entropy_t got, input entropy_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Register access and waits
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re   = 1'b0;
    data     = reg_rdata;
  endtask

  task automatic take_entropy(output entropy_t word);
    if (edn_words.size() == 0) begin
      errors++;
      $display("The EDN responder sent no entropy word for this reseed");
      word = '0;
    end else begin
      word = edn_words.pop_front();
    end
  endtask

  // Polls STATUS until the given busy bits are all low
  task automatic wait_reseed_done(input reg_data_t busy_mask);
    reg_data_t status;
    bit        seen;
    bit        done;
    seen = 1'b0;
    done = 1'b0;
    for (int i = 0; i < 200 && !done; i++) begin
      read_reg(`AES_ADDR_STATUS, status);
      if ((status & busy_mask) != '0) seen = 1'b1;
      else done = 1'b1;
    end
    if (!seen) begin
      errors++;
      $display("A reseed was expected but its busy bit never went high");
    end
    if (!done) begin
      errors++;
      $display("Timeout while waiting for a reseed to finish");
    end else begin
      check_data("reg_rdata_o", status, 32'h1);
    end
  endtask

  task automatic wait_edn_req(input logic level);
    int cycles;
    cycles = 0;
    while (edn_req !== level && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (edn_req !== level) begin
      errors++;
      $display("Timeout while waiting for edn_req_o to become %0b", level);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (idle !== 1'b1 && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (idle !== 1'b1) begin
      errors++;
      $display("Timeout while waiting for idle_o to return high");
    end
  endtask

  task automatic finish_clear_reseed();
    entropy_t word;
    wait_reseed_done(32'h2);
    take_entropy(word);
    clear_state = reseed_value(word, `AES_LFSR_SEED_CLEAR);
  endtask

  task automatic read_clear_word();
    reg_data_t data;
    read_reg(`AES_ADDR_CLEAR_DATA, data);
    check_word("clear_data", entropy_t'(data), clear_state);
    clear_state = lfsr_step(clear_state);
  endtask

  // Every PERIOD-th masking read starts an automatic reseed
  task automatic read_mask_word();
    reg_data_t data;
    entropy_t  word;
    read_reg(`AES_ADDR_MASK_DATA, data);
    check_word("mask_data", entropy_t'(data), mask_state);
    mask_state = lfsr_step(mask_state);
    mask_reads++;
    if (mask_reads == `AES_MASK_RESEED_PERIOD) begin
      mask_reads = 0;
      wait_reseed_done(32'h4);
      take_entropy(word);
      mask_state = reseed_value(word, `AES_LFSR_SEED_MASK);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reg_data_t data;
    entropy_t  word;
    rst_n          = 1'b0;
    rst_edn_n      = 1'b0;
    reg_we         = 1'b0;
    reg_re         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    lc_escalate_en = 1'b0;
    hold_ack       = 1'b0;
    force_zero     = 1'b0;
    errors         = 0;
    checks         = 0;
    mask_reads     = 0;
    clear_state    = `AES_LFSR_SEED_CLEAR;
    mask_state     = `AES_LFSR_SEED_MASK;
    repeat (2) @(negedge clk);
    rst_n     = 1'b1;
    rst_edn_n = 1'b1;
    @(negedge clk);

    // Reset values and free-running words from the seeds
    check_bit("idle_o", idle, 1'b1);
    check_bit("edn_req_o", edn_req, 1'b0);
    check_bit("alert_recov_o", alert_recov, 1'b0);
    check_bit("alert_fatal_o", alert_fatal, 1'b0);
    read_reg(`AES_ADDR_STATUS, data);
    check_data("reg_rdata_o", data, 32'h1);
    repeat (3) read_clear_word();
    repeat (3) read_mask_word();

    // Two software reseeds of the clearing PRNG with zero entropy in the second
    write_reg(`AES_ADDR_CTRL, 32'h1);
    finish_clear_reseed();
    repeat (3) read_clear_word();
    force_zero = 1'b1;
    write_reg(`AES_ADDR_CTRL, 32'h1);
    finish_clear_reseed();
    force_zero = 1'b0;
    repeat (2) read_clear_word();

    // Automatic masking reseed falls inside these reads
    repeat (`AES_MASK_RESEED_PERIOD) read_mask_word();

    // Both at once with clearing served first
    write_reg(`AES_ADDR_CTRL, 32'h3);
    wait_reseed_done(32'h6);
    take_entropy(word);
    clear_state = reseed_value(word, `AES_LFSR_SEED_CLEAR);
    take_entropy(word);
    mask_state = reseed_value(word, `AES_LFSR_SEED_MASK);
    repeat (2) read_clear_word();
    repeat (2) read_mask_word();

    // Reseed command while busy and then the alert test bits
    write_reg(`AES_ADDR_CTRL, 32'h1);
    check_bit("alert_recov_o", alert_recov, 1'b0);
    write_reg(`AES_ADDR_CTRL, 32'h1);
    check_bit("alert_recov_o", alert_recov, 1'b1);
    @(negedge clk);
    check_bit("alert_recov_o", alert_recov, 1'b0);
    finish_clear_reseed();
    read_clear_word();
    write_reg(`AES_ADDR_ALERT_TEST, 32'h1);
    check_bit("alert_recov_o", alert_recov, 1'b1);
    check_bit("alert_fatal_o", alert_fatal, 1'b0);
    @(negedge clk);
    check_bit("alert_recov_o", alert_recov, 1'b0);
    write_reg(`AES_ADDR_ALERT_TEST, 32'h2);
    check_bit("alert_fatal_o", alert_fatal, 1'b1);
    @(negedge clk);
    check_bit("alert_fatal_o", alert_fatal, 1'b0);
    read_reg(`AES_ADDR_STATUS, data);
    check_data("reg_rdata_o", data, 32'h1);

    // Escalation with an EDN request left open
    hold_ack = 1'b1;
    write_reg(`AES_ADDR_CTRL, 32'h1);
    wait_edn_req(1'b1);
    lc_escalate_en = 1'b1;
    @(negedge clk);
    check_bit("alert_fatal_o", alert_fatal, 1'b0);
    @(negedge clk);
    check_bit("alert_fatal_o", alert_fatal, 1'b1);
    read_reg(`AES_ADDR_STATUS, data);
    check_data("reg_rdata_o", data, 32'h8);
    read_reg(`AES_ADDR_CLEAR_DATA, data);
    check_word("clear_data", entropy_t'(data), '0);
    read_reg(`AES_ADDR_MASK_DATA, data);
    check_word("mask_data", entropy_t'(data), '0);
    check_bit("edn_req_o", edn_req, 1'b1);

    // Fatal state stays latched after escalation is released
    lc_escalate_en = 1'b0;
    hold_ack = 1'b0;
    wait_edn_req(1'b0);
    wait_idle();
    take_entropy(word);
    check_bit("alert_fatal_o", alert_fatal, 1'b1);
    read_reg(`AES_ADDR_STATUS, data);
    check_data("reg_rdata_o", data, 32'h9);
    read_reg(`AES_ADDR_CLEAR_DATA, data);
    check_word("clear_data", entropy_t'(data), '0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/aes_tb_clk.sv
//////////////////////////////////////////////////////////////////////
// Free-running testbench clock with a configurable period in ns
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module aes_tb_clk #(
  parameter real Period = 4.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
